// File: hdl/decode_unit.sv
`timescale 1ns/10ps

module decode_unit (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::fetch_t    fetch,
  output rv_pkg::reg_addr_t rs1_addr,
  output rv_pkg::reg_addr_t rs2_addr,
  input  rv_pkg::word_t     rs1_data,
  input  rv_pkg::word_t     rs2_data,
  output rv_pkg::exec_t     exec
);

  rv_pkg::fetch_t    dec_q;
  rv_pkg::exec_t     dec_next;
  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  rv_pkg::reg_addr_t rd;
  rv_pkg::word_t     imm_i;
  rv_pkg::word_t     imm_shamt;
  rv_pkg::word_t     imm_u;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_q <= '{pc: '0, insn: '0, status: rv_pkg::cycle_reset};
    end else begin
      dec_q <= fetch;
    end
  end

  // field split
  assign opcode   = dec_q.insn[6:0];
  assign rd       = dec_q.insn[11:7];
  assign funct3   = dec_q.insn[14:12];
  assign rs1_addr = dec_q.insn[19:15];
  assign rs2_addr = dec_q.insn[24:20];
  assign funct7   = dec_q.insn[31:25];

  assign imm_i     = {{20{dec_q.insn[31]}}, dec_q.insn[31:20]};
  assign imm_shamt = {27'b0, dec_q.insn[24:20]};
  assign imm_u     = {dec_q.insn[31:12], 12'b0};

  always_comb begin
    dec_next = '0;
    dec_next.pc = dec_q.pc;
    dec_next.insn = dec_q.insn;
    dec_next.rd = rd;
    dec_next.rs1 = rs1_addr;
    dec_next.rs2 = rs2_addr;
    dec_next.rs1_data = rs1_data;
    dec_next.rs2_data = rs2_data;
    dec_next.imm = imm_i;
    dec_next.alu_op = rv_pkg::alu_add;
    dec_next.status = dec_q.status;
    case (opcode)
      rv_pkg::op_reg_imm: begin
        dec_next.use_imm = 1'b1;
        dec_next.reg_write = 1'b1;
        case (funct3)
          3'b010: dec_next.alu_op = rv_pkg::alu_slt;
          3'b011: dec_next.alu_op = rv_pkg::alu_sltu;
          3'b100: dec_next.alu_op = rv_pkg::alu_xor;
          3'b110: dec_next.alu_op = rv_pkg::alu_or;
          3'b111: dec_next.alu_op = rv_pkg::alu_and;
          3'b001: begin
            dec_next.imm = imm_shamt;
            dec_next.alu_op = rv_pkg::alu_sll;
            dec_next.reg_write = (funct7 == 7'b0);
          end
          3'b101: begin
            // funct7 tells logical from arithmetic shift
            dec_next.imm = imm_shamt;
            dec_next.alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            dec_next.reg_write = (funct7 == 7'b0) || (funct7 == rv_pkg::funct7_alt);
          end
          default: dec_next.alu_op = rv_pkg::alu_add;
        endcase
      end
      rv_pkg::op_reg_reg: begin
        dec_next.reg_write = 1'b1;
        if (funct7 == 7'b0) begin
          case (funct3)
            3'b000: dec_next.alu_op = rv_pkg::alu_add;
            3'b001: dec_next.alu_op = rv_pkg::alu_sll;
            3'b010: dec_next.alu_op = rv_pkg::alu_slt;
            3'b011: dec_next.alu_op = rv_pkg::alu_sltu;
            3'b100: dec_next.alu_op = rv_pkg::alu_xor;
            3'b101: dec_next.alu_op = rv_pkg::alu_srl;
            3'b110: dec_next.alu_op = rv_pkg::alu_or;
            default: dec_next.alu_op = rv_pkg::alu_and;
          endcase
        end else if (funct7 == rv_pkg::funct7_alt && funct3 == 3'b000) begin
          dec_next.alu_op = rv_pkg::alu_sub;
        end else if (funct7 == rv_pkg::funct7_alt && funct3 == 3'b101) begin
          dec_next.alu_op = rv_pkg::alu_sra;
        end else begin
          dec_next.reg_write = 1'b0;
        end
      end
      rv_pkg::op_lui: begin
        dec_next.imm = imm_u;
        dec_next.use_imm = 1'b1;
        dec_next.alu_op = rv_pkg::alu_pass_imm;
        dec_next.reg_write = 1'b1;
      end
      rv_pkg::op_system: begin
        dec_next.is_ecall = (dec_q.insn[31:7] == 25'd0);
      end
      default: dec_next.reg_write = 1'b0;
    endcase
    // x0 writes are dropped here
    if (rd == '0) begin
      dec_next.reg_write = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      exec <= '0;
      exec.status <= rv_pkg::cycle_reset;
    end else begin
      exec <= dec_next;
    end
  end

  a_alu_op_defined: assert property (
    @(posedge clk) disable iff (rst)
    exec.reg_write |-> exec.alu_op <= rv_pkg::alu_pass_imm
  );

endmodule

// File: hdl/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::exec_t     exec,
  output logic              wr_en,
  output rv_pkg::reg_addr_t wr_addr,
  output rv_pkg::word_t     wr_data,
  output logic              halt,
  output rv_pkg::wb_t       trace
);

  rv_pkg::wb_t   wb_q;
  logic          halt_q;
  logic          fwd_a;
  logic          fwd_b;
  rv_pkg::word_t op_a;
  rv_pkg::word_t src_b;
  rv_pkg::word_t op_b;
  rv_pkg::word_t alu_out;

  // forward from writeback, one instruction behind
  assign fwd_a = wb_q.reg_write && (wb_q.rd == exec.rs1);
  assign fwd_b = wb_q.reg_write && (wb_q.rd == exec.rs2);

  assign op_a  = fwd_a ? wb_q.data : exec.rs1_data;
  assign src_b = fwd_b ? wb_q.data : exec.rs2_data;
  assign op_b  = exec.use_imm ? exec.imm : src_b;

  always_comb begin
    case (exec.alu_op)
      rv_pkg::alu_add:      alu_out = op_a + op_b;
      rv_pkg::alu_sub:      alu_out = op_a - op_b;
      rv_pkg::alu_sll:      alu_out = op_a << op_b[4:0];
      rv_pkg::alu_slt:      alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_pkg::alu_sltu:     alu_out = {31'b0, op_a < op_b};
      rv_pkg::alu_xor:      alu_out = op_a ^ op_b;
      rv_pkg::alu_srl:      alu_out = op_a >> op_b[4:0];
      rv_pkg::alu_sra:      alu_out = $signed(op_a) >>> op_b[4:0];
      rv_pkg::alu_or:       alu_out = op_a | op_b;
      rv_pkg::alu_and:      alu_out = op_a & op_b;
      rv_pkg::alu_pass_imm: alu_out = op_b;
      default:              alu_out = '0;
    endcase
  end

  // halt_q doubles as the sticky stop flag: everything after the ecall is a bubble
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_q <= '{
        status: rv_pkg::cycle_reset,
        pc: '0,
        insn: '0,
        reg_write: 1'b0,
        rd: '0,
        data: '0
      };
      halt_q <= 1'b0;
    end else if (halt_q) begin
      wb_q <= '{
        status: rv_pkg::cycle_invalid,
        pc: '0,
        insn: '0,
        reg_write: 1'b0,
        rd: '0,
        data: '0
      };
    end else begin
      wb_q <= '{
        status: exec.status,
        pc: exec.pc,
        insn: exec.insn,
        reg_write: exec.reg_write,
        rd: exec.rd,
        data: alu_out
      };
      halt_q <= exec.is_ecall && (exec.status == rv_pkg::cycle_no_stall);
    end
  end

  assign wr_en   = wb_q.reg_write;
  assign wr_addr = wb_q.rd;
  assign wr_data = wb_q.data;
  assign halt    = halt_q;
  assign trace   = wb_q;

  // only reset releases a halted core
  a_halt_sticky: assert property (
    @(posedge clk) halt_q && !rst |=> halt_q
  );

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit (
  input  logic           clk,
  input  logic           rst,
  input  logic           halt,
  output rv_pkg::word_t  imem_addr,
  input  rv_pkg::word_t  imem_data,
  output rv_pkg::fetch_t fetch
);

  rv_pkg::word_t pc_q;

  // pc freezes once the core halts
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
    end else if (!halt) begin
      pc_q <= pc_q + rv_pkg::pc_step;
    end
  end

  assign imem_addr = pc_q;

  // status shows cycle_reset while the core is in reset
  assign fetch = '{
    pc: pc_q,
    insn: imem_data,
    status: rst ? rv_pkg::cycle_reset : rv_pkg::cycle_no_stall
  };

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/10ps

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              wr_en,
  input  rv_pkg::reg_addr_t wr_addr,
  input  rv_pkg::word_t     wr_data
);

  rv_pkg::word_t regs [rv_pkg::num_regs];

  // x0 reads zero, a same-cycle write is passed straight through
  function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else if (wr_en && wr_addr == addr) begin
      return wr_data;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rv_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs1_data = read_port(rs1_addr);
  assign rs2_data = read_port(rs2_addr);

  // decode drops every write aimed at x0
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (rst)
    wr_en |-> wr_addr != '0
  );

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/10ps

module rv_core (
  input  logic          clk,
  input  logic          rst,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_data,
  output logic          halt,
  output rv_pkg::wb_t   trace
);

  rv_pkg::fetch_t    fetch;
  rv_pkg::exec_t     exec;
  rv_pkg::reg_addr_t rs1_addr;
  rv_pkg::reg_addr_t rs2_addr;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;
  logic              wr_en;
  rv_pkg::reg_addr_t wr_addr;
  rv_pkg::word_t     wr_data;

  fetch_unit u_fetch (
    .clk       (clk),
    .rst       (rst),
    .halt      (halt),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .fetch     (fetch)
  );

  decode_unit u_decode (
    .clk      (clk),
    .rst      (rst),
    .fetch    (fetch),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .exec     (exec)
  );

  // write port is steered from the writeback register in execute
  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  execute_unit u_execute (
    .clk     (clk),
    .rst     (rst),
    .exec    (exec),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .halt    (halt),
    .trace   (trace)
  );

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;
  localparam int num_regs = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  // next sequential instruction
  localparam word_t pc_step = 32'd4;

  // opcodes of the supported groups
  localparam logic [6:0] op_reg_imm = 7'b0010011;
  localparam logic [6:0] op_reg_reg = 7'b0110011;
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_system = 7'b1110011;

  // selects sub, sra and srai
  localparam logic [6:0] funct7_alt = 7'b0100000;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_imm
  } alu_op_e;

  // what the writeback slot holds in a given cycle
  typedef enum logic [1:0] {
    cycle_invalid = 2'd0,
    cycle_reset = 2'd1,
    cycle_no_stall = 2'd2
  } cycle_status_e;

  typedef struct packed {
    word_t pc;
    word_t insn;
    cycle_status_e status;
  } fetch_t;

  typedef struct packed {
    word_t pc;
    word_t insn;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t rs1_data;
    word_t rs2_data;
    word_t imm;
    alu_op_e alu_op;
    logic use_imm;
    logic reg_write;
    logic is_ecall;
    cycle_status_e status;
  } exec_t;

  typedef struct packed {
    cycle_status_e status;
    word_t pc;
    word_t insn;
    logic reg_write;
    reg_addr_t rd;
    word_t data;
  } wb_t;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_core -f verilog.f -Mdir obj_dir -o tb_core_sim \
  && ./obj_dir/tb_core_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: testbench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
  output logic clk
);

  // 4 ns period
  localparam int half_period = 2;

  initial begin
    clk = 1'b0;
  end

  always begin
    #half_period clk = ~clk;
  end

endmodule

// File: testbench/tb_core.sv
`timescale 1ns/10ps

module tb_core;

  localparam int max_cycles = 2000;
  localparam logic [31:0] ecall_word = 32'h0000_0073;

  logic          clk;
  logic          rst;
  rv_pkg::word_t imem_addr;
  rv_pkg::word_t imem_data;
  logic          halt;
  rv_pkg::wb_t   trace;

  logic [31:0] imem [256];
  logic [31:0] shadow [32];
  rv_pkg::wb_t exp_q [$];
  int          prog_len;
  logic        model_halted;
  int          cycle_count = 0;
  int          errors;
  int          pass_count = 0;
  int          fail_count = 0;
  integer      seed = 32'h26ad;
  string       test_name;

  tb_clock clock_gen (.clk(clk));

  rv_core UUT (
    .clk       (clk),
    .rst       (rst),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .halt      (halt),
    .trace     (trace)
  );

  // combinational instruction memory, word addressed
  assign imem_data = imem[imem_addr[9:2]];

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout after %0d cycles, the core never finished its program", max_cycles);
      $display("Test failed");
      $finish;
    end
  end

  task automatic mismatch(input string field, input logic [31:0] expected,
                          input logic [31:0] actual);
    $display("MISMATCH %s %s: expected %h actual %h", test_name, field, expected, actual);
    errors++;
  endtask

  task automatic complain(input string msg);
    $display("ERROR %s: %s", test_name, msg);
    errors++;
  endtask

  function automatic logic [31:0] itype(input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, rv_pkg::op_reg_imm};
  endfunction

  function automatic logic [31:0] shift_imm(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] shamt);
    return {f7, shamt, rs1, f3, rd, rv_pkg::op_reg_imm};
  endfunction

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, rv_pkg::op_reg_reg};
  endfunction

  task automatic new_program(input string name);
    test_name = name;
    errors = 0;
    prog_len = 0;
    model_halted = 1'b0;
    exp_q.delete();
    // unsupported custom opcode, upper bits carry the word index
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i << 7) | 32'h0000_000b;
    end
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
  endtask

  // RV32I reference: place the word in memory and queue its writeback
  task automatic emit(input logic [31:0] insn);
    rv_pkg::wb_t e;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] data;
    logic [4:0]  sh;
    logic        valid;
    a = shadow[insn[19:15]];
    b = shadow[insn[24:20]];
    imm = {{20{insn[31]}}, insn[31:20]};
    sh = insn[24:20];
    data = '0;
    valid = 1'b1;
    if (insn[6:0] == 7'b0010011) begin
      case (insn[14:12])
        3'b000: data = a + imm;
        3'b010: data = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
        3'b011: data = (a < imm) ? 32'd1 : 32'd0;
        3'b100: data = a ^ imm;
        3'b110: data = a | imm;
        3'b111: data = a & imm;
        3'b001: begin
          data = a << sh;
          valid = (insn[31:25] == 7'h00);
        end
        default: begin
          if (insn[30]) begin
            data = $signed(a) >>> sh;
          end else begin
            data = a >> sh;
          end
          valid = (insn[31:25] == 7'h00) || (insn[31:25] == 7'h20);
        end
      endcase
    end else if (insn[6:0] == 7'b0110011) begin
      case ({insn[31:25], insn[14:12]})
        {7'h00, 3'b000}: data = a + b;
        {7'h20, 3'b000}: data = a - b;
        {7'h00, 3'b001}: data = a << b[4:0];
        {7'h00, 3'b010}: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        {7'h00, 3'b011}: data = (a < b) ? 32'd1 : 32'd0;
        {7'h00, 3'b100}: data = a ^ b;
        {7'h00, 3'b101}: data = a >> b[4:0];
        {7'h20, 3'b101}: data = $signed(a) >>> b[4:0];
        {7'h00, 3'b110}: data = a | b;
        {7'h00, 3'b111}: data = a & b;
        default: valid = 1'b0;
      endcase
    end else if (insn[6:0] == 7'b0110111) begin
      data = {insn[31:12], 12'h000};
    end else begin
      valid = 1'b0;
    end
    e = '0;
    e.status = rv_pkg::cycle_no_stall;
    e.pc = 32'(prog_len * 4);
    e.insn = insn;
    e.rd = insn[11:7];
    e.reg_write = valid && (insn[11:7] != 5'd0);
    e.data = data;
    imem[prog_len] = insn;
    prog_len++;
    // nothing after the ecall retires
    if (!model_halted) begin
      if (e.reg_write) begin
        shadow[e.rd] = data;
      end
      exp_q.push_back(e);
    end
    if (insn == ecall_word) begin
      model_halted = 1'b1;
    end
  endtask

  // lui plus addi, upper part rounded for the sign of the low twelve bits
  task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit({upper[31:12], rd, rv_pkg::op_lui});
    emit(itype(3'b000, rd, rd, value[11:0]));
  endtask

  task automatic check_reset_state;
    if (trace.status !== rv_pkg::cycle_reset) begin
      complain("trace status is not cycle_reset around reset");
    end
    if (halt !== 1'b0) begin
      complain("halt is high during or right after reset");
    end
  endtask

  task automatic run_program;
    rv_pkg::wb_t e;
    logic        exp_halt;
    logic [31:0] exp_fetch;
    exp_fetch = '0;
    rst = 1'b1;
    repeat (10) begin
      @(posedge clk);
      #1;
      check_reset_state();
    end
    rst = 1'b0;
    // two more cycles before pc 0 reaches writeback
    repeat (2) begin
      @(posedge clk);
      #1;
      check_reset_state();
    end
    while (exp_q.size() > 0) begin
      @(posedge clk);
      #1;
      e = exp_q.pop_front();
      exp_halt = (e.insn == ecall_word);
      // fetch runs three words ahead of writeback
      exp_fetch = e.pc + 32'd12;
      if (trace.status !== e.status) begin
        mismatch("status", 32'(e.status), 32'(trace.status));
      end
      if (trace.pc !== e.pc) begin
        mismatch("pc", e.pc, trace.pc);
      end
      if (trace.insn !== e.insn) begin
        mismatch("insn", e.insn, trace.insn);
      end
      if (trace.reg_write !== e.reg_write) begin
        mismatch("reg_write", 32'(e.reg_write), 32'(trace.reg_write));
      end
      if (e.reg_write && trace.rd !== e.rd) begin
        mismatch("rd", 32'(e.rd), 32'(trace.rd));
      end
      if (e.reg_write && trace.data !== e.data) begin
        mismatch("data", e.data, trace.data);
      end
      if (halt !== exp_halt) begin
        mismatch("halt", 32'(exp_halt), 32'(halt));
      end
      if (imem_addr !== exp_fetch) begin
        mismatch("imem_addr", exp_fetch, imem_addr);
      end
    end
    repeat (8) begin
      @(posedge clk);
      #1;
      if (trace.status == rv_pkg::cycle_no_stall || trace.reg_write !== 1'b0) begin
        complain("an instruction after the ecall reached writeback");
      end
      if (halt !== 1'b1) begin
        complain("halt did not stay high after the ecall");
      end
      // pc is held while halted
      if (imem_addr !== exp_fetch) begin
        mismatch("imem_addr", exp_fetch, imem_addr);
      end
    end
    if (errors == 0) begin
      pass_count++;
      $display("%s: passed", test_name);
    end else begin
      fail_count++;
      $display("%s: failed with %0d errors", test_name, errors);
    end
  endtask

  task automatic test_reset_order;
    new_program("reset_order");
    for (int i = 1; i < 9; i++) begin
      emit(itype(3'b000, 5'(i), 5'(i - 1), 12'(i * 7)));
    end
    // custom opcode with rd x1, must not write
    emit(32'h0000_00ab);
    emit(ecall_word);
    run_program();
  endtask

  task automatic test_reg_imm;
    logic [31:0] r;
    logic [11:0] neg;
    new_program("reg_imm");
    set_reg(5'd1, $random(seed));
    r = $random(seed);
    set_reg(5'd2, r | 32'h8000_0000);
    r = $random(seed);
    emit({r[19:0], 5'd3, rv_pkg::op_lui});
    r = $random(seed);
    emit({r[19:0] | 20'h80000, 5'd4, rv_pkg::op_lui});
    r = $random(seed);
    neg = r[11:0] | 12'h800;
    emit(itype(3'b000, 5'd5, 5'd1, r[11:0]));
    emit(itype(3'b000, 5'd6, 5'd2, neg));
    emit(itype(3'b010, 5'd7, 5'd2, neg));
    emit(itype(3'b010, 5'd8, 5'd1, r[11:0]));
    emit(itype(3'b011, 5'd9, 5'd1, neg));
    emit(itype(3'b100, 5'd10, 5'd1, neg));
    emit(itype(3'b110, 5'd11, 5'd3, r[11:0]));
    emit(itype(3'b111, 5'd12, 5'd2, neg));
    emit(shift_imm(7'h00, 3'b001, 5'd13, 5'd1, r[16:12]));
    emit(shift_imm(7'h00, 3'b101, 5'd14, 5'd2, r[21:17]));
    emit(shift_imm(rv_pkg::funct7_alt, 3'b101, 5'd15, 5'd2, r[26:22]));
    emit(shift_imm(rv_pkg::funct7_alt, 3'b101, 5'd16, 5'd4, r[31:27]));
    emit(ecall_word);
    run_program();
  endtask

  task automatic test_reg_reg;
    logic [31:0] r;
    new_program("reg_reg");
    set_reg(5'd1, $random(seed));
    set_reg(5'd2, $random(seed));
    r = $random(seed);
    set_reg(5'd3, r | 32'h8000_0000);
    r = $random(seed);
    set_reg(5'd4, r & 32'h7fff_ffff);
    emit(rtype(7'h00, 3'b000, 5'd5, 5'd1, 5'd2));
    emit(rtype(7'h20, 3'b000, 5'd6, 5'd1, 5'd2));
    // zero minus a positive value wraps
    emit(rtype(7'h20, 3'b000, 5'd7, 5'd0, 5'd4));
    emit(rtype(7'h00, 3'b001, 5'd8, 5'd1, 5'd2));
    emit(rtype(7'h00, 3'b010, 5'd9, 5'd3, 5'd4));
    emit(rtype(7'h00, 3'b011, 5'd10, 5'd3, 5'd4));
    emit(rtype(7'h00, 3'b010, 5'd11, 5'd4, 5'd3));
    emit(rtype(7'h00, 3'b011, 5'd12, 5'd4, 5'd3));
    emit(rtype(7'h00, 3'b100, 5'd13, 5'd1, 5'd3));
    emit(rtype(7'h00, 3'b101, 5'd14, 5'd3, 5'd2));
    emit(rtype(7'h20, 3'b101, 5'd15, 5'd3, 5'd2));
    emit(rtype(7'h00, 3'b110, 5'd16, 5'd1, 5'd2));
    emit(rtype(7'h00, 3'b111, 5'd17, 5'd1, 5'd3));
    // mul encoding is not supported
    emit(rtype(7'h01, 3'b000, 5'd18, 5'd1, 5'd2));
    emit(ecall_word);
    run_program();
  endtask

  task automatic test_bypass;
    logic [31:0] r;
    logic [6:0]  f7;
    new_program("bypass");
    set_reg(5'd1, $random(seed));
    r = $random(seed);
    emit(itype(3'b000, 5'd2, 5'd1, r[11:0]));
    // each op reads the previous two results
    for (int i = 3; i < 15; i++) begin
      f7 = (i == 8 || i == 13) ? rv_pkg::funct7_alt : 7'h00;
      emit(rtype(f7, 3'(i), 5'(i), 5'(i - 1), 5'(i - 2)));
    end
    r = $random(seed);
    emit(itype(3'b000, 5'd0, 5'd14, r[11:0]));
    emit(rtype(7'h00, 3'b000, 5'd15, 5'd0, 5'd14));
    emit(rtype(7'h00, 3'b110, 5'd16, 5'd0, 5'd0));
    emit(itype(3'b000, 5'd17, 5'd16, 12'd1));
    emit(ecall_word);
    run_program();
  endtask

  task automatic test_halt;
    logic [31:0] r;
    new_program("halt");
    r = $random(seed);
    set_reg(5'd1, r);
    emit(itype(3'b000, 5'd2, 5'd1, 12'd5));
    emit(ecall_word);
    emit(itype(3'b000, 5'd3, 5'd1, 12'd1));
    emit(rtype(7'h00, 3'b000, 5'd4, 5'd1, 5'd2));
    emit({r[31:12], 5'd5, rv_pkg::op_lui});
    run_program();
  endtask

  initial begin
    rst = 1'b1;
    test_reset_order();
    test_reg_imm();
    test_reg_reg();
    test_bypass();
    test_halt();
    $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
hdl/rv_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/execute_unit.sv
hdl/rv_core.sv
testbench/tb_clock.sv
testbench/tb_core.sv
